//--- rtl/secv_settings.svh
// SEC-V memory subsystem settings
`ifndef SECV_SETTINGS_SVH
`define SECV_SETTINGS_SVH

// Data path
`define SECV_XLEN 64
`define SECV_ADR_WIDTH 9

// Bit 8 set means outside the 256 usable bytes
`define SECV_ADR_FAULT_MASK 9'h100

// Interleaved data banks, bank index in address bits 4:3
`define SECV_DMEM_BANKS 4
`define SECV_BANK_DEPTH 8
`define SECV_WORD_LSB 3

// Memory tags, one per 16-byte granule
`define SECV_TLEN 16
`define SECV_TAG_DEPTH 16
`define SECV_GRANULE_LSB 4

// Pointer key sits in src1 bits 63:48
`define SECV_TAG_KEY_LSB 48

`endif

//--- rtl/secv_pkg.sv
// SEC-V shared types
`default_nettype none
`include "secv_settings.svh"

package secv_pkg;

    typedef logic [`SECV_XLEN-1:0] xword_t;
    typedef logic [`SECV_TLEN-1:0] mtag_t;

    // Memory ops, codes 11 to 15 are invalid
    typedef enum logic [3:0] {
        MEM_OP_LB,
        MEM_OP_LH,
        MEM_OP_LW,
        MEM_OP_LD,
        MEM_OP_LBU,
        MEM_OP_LHU,
        MEM_OP_LWU,
        MEM_OP_SB,
        MEM_OP_SH,
        MEM_OP_SW,
        MEM_OP_SD
    } mem_op_t;

    typedef enum logic [3:0] {
        ECODE_OP_INVALID         = 4'd2,
        ECODE_LOAD_ACCESS_FAULT  = 4'd5,
        ECODE_STORE_ACCESS_FAULT = 4'd7,
        ECODE_TAG_FAULT          = 4'd12
    } ecode_t;

    typedef struct packed {
        logic    ena;
        mem_op_t op;
        xword_t  src1;
        xword_t  src2;
    } funit_in_t;

    typedef struct packed {
        logic   rdy;
        logic   err;
        ecode_t ecode;
        xword_t res;
        logic   res_wb;
    } funit_out_t;

    function automatic xword_t sext8(input logic [7:0] v);
        return {{(`SECV_XLEN-8){v[7]}}, v};
    endfunction

    function automatic xword_t sext16(input logic [15:0] v);
        return {{(`SECV_XLEN-16){v[15]}}, v};
    endfunction

    function automatic xword_t sext32(input logic [31:0] v);
        return {{(`SECV_XLEN-32){v[31]}}, v};
    endfunction

    // Idle output, every field zero
    function automatic funit_out_t funit_out_default();
        funit_out_t o;
        o = '0;
        return o;
    endfunction

endpackage

`default_nettype wire

//--- rtl/wb_ram.sv
// Wishbone single-port RAM
`default_nettype none

module wb_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 16
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          cyc_i,
    input  wire logic                          stb_i,
    input  wire logic                          we_i,
    input  wire logic [$bits(word_t)/8-1:0]    sel_i,
    input  wire logic [$clog2(DEPTH)-1:0]      adr_i,
    input  wire word_t                         dat_i,
    output word_t                              dat_o,
    output logic                               ack_o
);

    localparam int W  = $bits(word_t);
    localparam int NB = W / 8;

    logic [W-1:0] mem_q [DEPTH];
    logic [W-1:0] wdat;
    logic [W-1:0] rdat_q;
    logic         ack_q;
    logic         acc;

    assign wdat = dat_i;

    // One access per strobe, the ack cycle itself is not served again
    assign acc = cyc_i & stb_i & ~ack_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc;
        end
    end

    // Byte lane writes and registered read
    always_ff @(posedge clk_i) begin
        if (acc) begin
            if (we_i) begin
                for (int b = 0; b < NB; b++) begin
                    if (sel_i[b]) begin
                        mem_q[adr_i][b*8 +: 8] <= wdat[b*8 +: 8];
                    end
                end
            end else begin
                rdat_q <= mem_q[adr_i];
            end
        end
    end

    assign dat_o = word_t'(rdat_q);
    assign ack_o = ack_q;

endmodule

`default_nettype wire

//--- rtl/dmem_bank_dec.sv
// Data bank decoder
`default_nettype none
`include "secv_settings.svh"

module dmem_bank_dec (
    input  wire logic                                 cyc_i,
    input  wire logic                                 stb_i,
    input  wire logic [`SECV_ADR_WIDTH-1:0]           adr_i,
    output logic [`SECV_DMEM_BANKS-1:0]               bank_cyc_o,
    output logic [`SECV_DMEM_BANKS-1:0]               bank_stb_o,
    output logic [$clog2(`SECV_BANK_DEPTH)-1:0]       bank_adr_o
);

    localparam int BW  = $clog2(`SECV_DMEM_BANKS);
    localparam int BAW = $clog2(`SECV_BANK_DEPTH);

    logic [BW-1:0] bank;

    // Bank index right above the word offset, row above that
    assign bank       = adr_i[`SECV_WORD_LSB +: BW];
    assign bank_adr_o = adr_i[`SECV_WORD_LSB + BW +: BAW];

    always_comb begin
        bank_cyc_o = '0;
        bank_stb_o = '0;
        bank_cyc_o[bank] = cyc_i;
        bank_stb_o[bank] = stb_i;
    end

endmodule

`default_nettype wire

//--- rtl/dmem_resp_mux.sv
// Data bank response mux
`default_nettype none
`include "secv_settings.svh"

module dmem_resp_mux (
    input  wire logic [`SECV_DMEM_BANKS-1:0]  bank_ack_i,
    input  wire secv_pkg::xword_t             bank_dat_i [`SECV_DMEM_BANKS],
    output logic                              ack_o,
    output secv_pkg::xword_t                  dat_o
);
    import secv_pkg::*;

    xword_t rd_dat;

    // At most one bank acks, so AND-OR acts as a select
    always_comb begin
        rd_dat = '0;
        for (int b = 0; b < `SECV_DMEM_BANKS; b++) begin
            rd_dat = rd_dat | (bank_dat_i[b] & {`SECV_XLEN{bank_ack_i[b]}});
        end
    end

    assign ack_o = |bank_ack_i;
    assign dat_o = rd_dat;

endmodule

`default_nettype wire

//--- rtl/mtag_chk.sv
// Memory tag checker
`default_nettype none
`include "secv_settings.svh"

module mtag_chk (
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    input  wire logic                                ena_i,
    input  wire logic                                skip_i,
    input  wire secv_pkg::xword_t                    adr_i,
    input  wire logic                                tag_wr_i,
    input  wire logic [$clog2(`SECV_TAG_DEPTH)-1:0]  tag_wr_adr_i,
    input  wire secv_pkg::mtag_t                     tag_wr_dat_i,
    output logic                                     tag_ok_o,
    output logic                                     tag_err_o,
    output logic                                     tmem_cyc_o,
    output logic                                     tmem_stb_o,
    output logic [`SECV_TLEN/8-1:0]                  tmem_sel_o,
    output logic [$clog2(`SECV_TAG_DEPTH)-1:0]       tmem_adr_o,
    output logic                                     tmem_we_o,
    output secv_pkg::mtag_t                          tmem_dat_o,
    input  wire secv_pkg::mtag_t                     tmem_dat_i,
    input  wire logic                                tmem_ack_i
);
    import secv_pkg::*;

    localparam int TAW = $clog2(`SECV_TAG_DEPTH);

    mtag_t key;
    logic  rd_req;
    logic  wr_req;
    logic  rd_ack;
    logic  match;
    logic  done_q;
    logic  ok_q;
    logic  wr_q;

    assign key    = adr_i[`SECV_TAG_KEY_LSB +: `SECV_TLEN];
    assign rd_req = ena_i & ~skip_i & ~done_q;
    // Programming only while the unit is idle
    assign wr_req = ~ena_i & tag_wr_i;
    // An ack right after a programming write belongs to that write
    assign rd_ack = ena_i & ~skip_i & ~done_q & tmem_ack_i & ~wr_q;
    assign match  = (tmem_dat_i == key);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
            ok_q   <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            wr_q <= wr_req;
            if (!ena_i) begin
                done_q <= 1'b0;
                ok_q   <= 1'b0;
            end else if (rd_ack) begin
                done_q <= 1'b1;
                ok_q   <= match;
            end
        end
    end

    // Result shows in the ack cycle, then holds while ena stays high
    assign tag_ok_o  = ena_i & (done_q ? ok_q : (rd_ack & match));
    assign tag_err_o = ena_i & (done_q ? ~ok_q : (rd_ack & ~match));

    assign tmem_cyc_o = rd_req | wr_req;
    assign tmem_stb_o = rd_req | wr_req;
    assign tmem_sel_o = '1;
    assign tmem_we_o  = wr_req;
    assign tmem_adr_o = wr_req ? tag_wr_adr_i : adr_i[`SECV_GRANULE_LSB +: TAW];
    assign tmem_dat_o = wr_req ? tag_wr_dat_i : '0;

endmodule

`default_nettype wire

//--- rtl/mem.sv
// Memory function unit
`default_nettype none
`include "secv_settings.svh"

module mem (
    input  wire secv_pkg::funit_in_t              fu_i,
    output secv_pkg::funit_out_t                  fu_o,
    input  wire logic                             tag_ok_i,
    input  wire logic                             tag_err_i,
    output logic                                  tag_err_o,
    output logic                                  early_err_o,
    output logic                                  dmem_cyc_o,
    output logic                                  dmem_stb_o,
    output logic [`SECV_XLEN/8-1:0]               dmem_sel_o,
    output logic [`SECV_ADR_WIDTH-1:0]            dmem_adr_o,
    output logic                                  dmem_we_o,
    output secv_pkg::xword_t                      dmem_dat_o,
    input  wire secv_pkg::xword_t                 dmem_dat_i,
    input  wire logic                             dmem_ack_i
);
    import secv_pkg::*;

    logic [`SECV_ADR_WIDTH-1:0] adr;
    logic [`SECV_XLEN/8-1:0]    sel;
    logic                       load;
    logic                       store;
    logic                       op_err;
    logic                       adr_err;
    logic                       bus_go;
    xword_t                     st_dat;
    xword_t                     ld_dat;

    assign adr = fu_i.src1[`SECV_ADR_WIDTH-1:0];

    // Op decode, data always in the low lanes
    always_comb begin
        sel    = '0;
        load   = 1'b0;
        store  = 1'b0;
        st_dat = '0;
        case (fu_i.op)
            MEM_OP_LB, MEM_OP_LBU: begin
                sel  = 8'h01;
                load = 1'b1;
            end
            MEM_OP_LH, MEM_OP_LHU: begin
                sel  = 8'h03;
                load = 1'b1;
            end
            MEM_OP_LW, MEM_OP_LWU: begin
                sel  = 8'h0f;
                load = 1'b1;
            end
            MEM_OP_LD: begin
                sel  = 8'hff;
                load = 1'b1;
            end
            MEM_OP_SB: begin
                sel         = 8'h01;
                store       = 1'b1;
                st_dat[7:0] = fu_i.src2[7:0];
            end
            MEM_OP_SH: begin
                sel          = 8'h03;
                store        = 1'b1;
                st_dat[15:0] = fu_i.src2[15:0];
            end
            MEM_OP_SW: begin
                sel          = 8'h0f;
                store        = 1'b1;
                st_dat[31:0] = fu_i.src2[31:0];
            end
            MEM_OP_SD: begin
                sel    = 8'hff;
                store  = 1'b1;
                st_dat = fu_i.src2;
            end
            default: ;
        endcase
    end

    // Load extension
    always_comb begin
        ld_dat = '0;
        case (fu_i.op)
            MEM_OP_LB:  ld_dat = sext8(dmem_dat_i[7:0]);
            MEM_OP_LH:  ld_dat = sext16(dmem_dat_i[15:0]);
            MEM_OP_LW:  ld_dat = sext32(dmem_dat_i[31:0]);
            MEM_OP_LBU: ld_dat[7:0] = dmem_dat_i[7:0];
            MEM_OP_LHU: ld_dat[15:0] = dmem_dat_i[15:0];
            MEM_OP_LWU: ld_dat[31:0] = dmem_dat_i[31:0];
            default:    ld_dat = dmem_dat_i;
        endcase
    end

    assign op_err  = ~(load | store);
    assign adr_err = |(adr & `SECV_ADR_FAULT_MASK);

    // Faults known before any bus access, no tag read needed
    assign early_err_o = fu_i.ena & (op_err | adr_err);
    assign tag_err_o   = fu_i.ena & tag_err_i;

    // Data bus only once the tag is confirmed
    assign bus_go     = fu_i.ena & ~op_err & ~adr_err & tag_ok_i;
    assign dmem_cyc_o = bus_go;
    assign dmem_stb_o = bus_go;
    assign dmem_sel_o = bus_go ? sel : '0;
    assign dmem_adr_o = bus_go ? adr : '0;
    assign dmem_we_o  = bus_go & store;
    assign dmem_dat_o = bus_go ? st_dat : '0;

    // Completion, tag fault wins over the data ack
    always_comb begin
        fu_o = funit_out_default();
        if (fu_i.ena) begin
            if (op_err) begin
                fu_o.rdy   = 1'b1;
                fu_o.err   = 1'b1;
                fu_o.ecode = ECODE_OP_INVALID;
            end else if (adr_err) begin
                fu_o.rdy   = 1'b1;
                fu_o.err   = 1'b1;
                if (load) begin
                    fu_o.ecode = ECODE_LOAD_ACCESS_FAULT;
                end else begin
                    fu_o.ecode = ECODE_STORE_ACCESS_FAULT;
                end
            end else if (tag_err_i) begin
                fu_o.rdy   = 1'b1;
                fu_o.err   = 1'b1;
                fu_o.ecode = ECODE_TAG_FAULT;
            end else if (dmem_ack_i) begin
                fu_o.rdy    = 1'b1;
                fu_o.res    = load ? ld_dat : '0;
                fu_o.res_wb = load;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_subsys.sv
// Memory subsystem top
`default_nettype none
`include "secv_settings.svh"

module mem_subsys (
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    input  wire secv_pkg::funit_in_t                 fu_i,
    output secv_pkg::funit_out_t                     fu_o,
    output logic                                     tag_err_o,
    input  wire logic                                tag_wr_i,
    input  wire logic [$clog2(`SECV_TAG_DEPTH)-1:0]  tag_wr_adr_i,
    input  wire secv_pkg::mtag_t                     tag_wr_dat_i
);
    import secv_pkg::*;

    localparam int BANKS = `SECV_DMEM_BANKS;
    localparam int BAW   = $clog2(`SECV_BANK_DEPTH);
    localparam int TAW   = $clog2(`SECV_TAG_DEPTH);

    logic                       tag_ok;
    logic                       tag_err;
    logic                       early_err;

    // Data bus
    logic                       dmem_cyc;
    logic                       dmem_stb;
    logic [`SECV_XLEN/8-1:0]    dmem_sel;
    logic [`SECV_ADR_WIDTH-1:0] dmem_adr;
    logic                       dmem_we;
    logic                       dmem_ack;
    xword_t                     dmem_wdat;
    xword_t                     dmem_rdat;

    // Tag bus
    logic                       tmem_cyc;
    logic                       tmem_stb;
    logic [`SECV_TLEN/8-1:0]    tmem_sel;
    logic [TAW-1:0]             tmem_adr;
    logic                       tmem_we;
    logic                       tmem_ack;
    mtag_t                      tmem_wdat;
    mtag_t                      tmem_rdat;

    logic [BANKS-1:0]           bank_cyc;
    logic [BANKS-1:0]           bank_stb;
    logic [BANKS-1:0]           bank_ack;
    logic [BAW-1:0]             bank_adr;
    xword_t                     bank_dat [BANKS];

    mem u_mem (
        .fu_i        (fu_i),
        .fu_o        (fu_o),
        .tag_ok_i    (tag_ok),
        .tag_err_i   (tag_err),
        .tag_err_o   (tag_err_o),
        .early_err_o (early_err),
        .dmem_cyc_o  (dmem_cyc),
        .dmem_stb_o  (dmem_stb),
        .dmem_sel_o  (dmem_sel),
        .dmem_adr_o  (dmem_adr),
        .dmem_we_o   (dmem_we),
        .dmem_dat_o  (dmem_wdat),
        .dmem_dat_i  (dmem_rdat),
        .dmem_ack_i  (dmem_ack)
    );

    mtag_chk u_mtag_chk (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ena_i        (fu_i.ena),
        .skip_i       (early_err),
        .adr_i        (fu_i.src1),
        .tag_wr_i     (tag_wr_i),
        .tag_wr_adr_i (tag_wr_adr_i),
        .tag_wr_dat_i (tag_wr_dat_i),
        .tag_ok_o     (tag_ok),
        .tag_err_o    (tag_err),
        .tmem_cyc_o   (tmem_cyc),
        .tmem_stb_o   (tmem_stb),
        .tmem_sel_o   (tmem_sel),
        .tmem_adr_o   (tmem_adr),
        .tmem_we_o    (tmem_we),
        .tmem_dat_o   (tmem_wdat),
        .tmem_dat_i   (tmem_rdat),
        .tmem_ack_i   (tmem_ack)
    );

    wb_ram #(
        .word_t (mtag_t),
        .DEPTH  (`SECV_TAG_DEPTH)
    ) u_tmem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (tmem_cyc),
        .stb_i   (tmem_stb),
        .we_i    (tmem_we),
        .sel_i   (tmem_sel),
        .adr_i   (tmem_adr),
        .dat_i   (tmem_wdat),
        .dat_o   (tmem_rdat),
        .ack_o   (tmem_ack)
    );

    dmem_bank_dec u_bank_dec (
        .cyc_i      (dmem_cyc),
        .stb_i      (dmem_stb),
        .adr_i      (dmem_adr),
        .bank_cyc_o (bank_cyc),
        .bank_stb_o (bank_stb),
        .bank_adr_o (bank_adr)
    );

    // Word-interleaved banks share sel, we and write data
    for (genvar i = 0; i < BANKS; i++) begin : g_bank
        wb_ram #(
            .word_t (xword_t),
            .DEPTH  (`SECV_BANK_DEPTH)
        ) u_ram (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .cyc_i   (bank_cyc[i]),
            .stb_i   (bank_stb[i]),
            .we_i    (dmem_we),
            .sel_i   (dmem_sel),
            .adr_i   (bank_adr),
            .dat_i   (dmem_wdat),
            .dat_o   (bank_dat[i]),
            .ack_o   (bank_ack[i])
        );
    end

    dmem_resp_mux u_resp_mux (
        .bank_ack_i (bank_ack),
        .bank_dat_i (bank_dat),
        .ack_o      (dmem_ack),
        .dat_o      (dmem_rdat)
    );

endmodule

`default_nettype wire

//--- bench/mem_subsys_props.sv
// Memory subsystem assertions
`default_nettype none
`include "secv_settings.svh"

module mem_subsys_props (
    input wire logic                          clk_i,
    input wire logic                          rst_n_i,
    input wire logic                          fu_ena_i,
    input wire logic                          fu_rdy_i,
    input wire logic [`SECV_DMEM_BANKS-1:0]   bank_ack_i,
    input wire logic [`SECV_DMEM_BANKS-1:0]   bank_stb_i,
    input wire logic                          tag_ok_i,
    input wire logic                          dmem_cyc_i,
    input wire logic                          dmem_stb_i,
    input wire logic                          tmem_cyc_i,
    input wire logic                          tmem_stb_i
);

    // Read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    a_rdy_with_ena: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fu_rdy_i |-> fu_ena_i)
        else begin
            $error("rdy without ena");
            fail_cnt++;
        end

    a_one_bank_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(bank_ack_i))
        else begin
            $error("more than one bank ack");
            fail_cnt++;
        end

    // Strobes as the banks see them
    a_stb_after_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|bank_stb_i) |-> tag_ok_i)
        else begin
            $error("data stb without tag ok");
            fail_cnt++;
        end

    a_quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> !(dmem_cyc_i || dmem_stb_i || tmem_cyc_i || tmem_stb_i))
        else begin
            $error("bus active during reset");
            fail_cnt++;
        end

endmodule

bind mem_subsys mem_subsys_props u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fu_ena_i   (fu_i.ena),
    .fu_rdy_i   (fu_o.rdy),
    .bank_ack_i (bank_ack),
    .bank_stb_i (bank_stb),
    .tag_ok_i   (tag_ok),
    .dmem_cyc_i (dmem_cyc),
    .dmem_stb_i (dmem_stb),
    .tmem_cyc_i (tmem_cyc),
    .tmem_stb_i (tmem_stb)
);

`default_nettype wire

//--- bench/mem_subsys_tb.sv
// Memory subsystem testbench
`default_nettype none
`include "secv_settings.svh"

module mem_subsys_tb;
    import secv_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRV_DLY        = 5;
    localparam int RST_CYCLES     = 16;
    localparam int MEM_BYTES      = 256;
    localparam int TAW            = $clog2(`SECV_TAG_DEPTH);
    localparam int N_RANDOM       = 500;
    localparam int N_REQ          = 600;
    localparam int TIMEOUT_CYCLES = N_REQ * 4 + 100;

    typedef struct {
        int     lat;
        logic   err;
        ecode_t ecode;
        xword_t res;
        logic   res_wb;
    } expect_t;

    logic           clk;
    logic           rst_n;
    funit_in_t      fu_in;
    funit_out_t     fu_out;
    logic           tag_err;
    logic           tag_wr;
    logic [TAW-1:0] tag_wr_adr;
    mtag_t          tag_wr_dat;

    // Byte memory and granule tags as the testbench sees them
    logic [7:0] mem_model [MEM_BYTES];
    mtag_t      tag_model [`SECV_TAG_DEPTH];

    expect_t exp_q;
    integer  seed       = 76690;
    int      err_cnt    = 0;
    int      chk_cnt    = 0;
    int      cycle_cnt  = 0;
    int      ena_cycles = 0;

    mem_subsys u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .fu_i         (fu_in),
        .fu_o         (fu_out),
        .tag_err_o    (tag_err),
        .tag_wr_i     (tag_wr),
        .tag_wr_adr_i (tag_wr_adr),
        .tag_wr_dat_i (tag_wr_dat)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int op_bytes(input mem_op_t op);
        case (op)
            MEM_OP_LB, MEM_OP_LBU, MEM_OP_SB: return 1;
            MEM_OP_LH, MEM_OP_LHU, MEM_OP_SH: return 2;
            MEM_OP_LW, MEM_OP_LWU, MEM_OP_SW: return 4;
            MEM_OP_LD, MEM_OP_SD:             return 8;
            default:                          return 0;
        endcase
    endfunction

    function automatic logic op_is_load(input mem_op_t op);
        return op inside {MEM_OP_LB, MEM_OP_LH, MEM_OP_LW, MEM_OP_LD,
                          MEM_OP_LBU, MEM_OP_LHU, MEM_OP_LWU};
    endfunction

    function automatic logic op_is_signed(input mem_op_t op);
        return op inside {MEM_OP_LB, MEM_OP_LH, MEM_OP_LW};
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 37 + 11);
    endfunction

    function automatic mtag_t fill_tag(input int g);
        return 16'(32'h5a3c ^ (g * 32'h1111));
    endfunction

    function automatic xword_t make_ptr(input mtag_t key, input logic [8:0] adr);
        return {key, {(`SECV_XLEN - `SECV_TLEN - `SECV_ADR_WIDTH){1'b0}}, adr};
    endfunction

    // Expected outcome of one request
    function automatic expect_t ref_result(input mem_op_t op, input xword_t a,
                                           input xword_t d,
                                           input logic [7:0] m [MEM_BYTES],
                                           input mtag_t t [`SECV_TAG_DEPTH]);
        expect_t e;
        int      n;
        int      base;
        mtag_t   key;
        e.lat    = 0;
        e.err    = 1'b0;
        e.ecode  = ECODE_OP_INVALID;
        e.res    = '0;
        e.res_wb = 1'b0;
        n        = op_bytes(op);
        key      = a[`SECV_TAG_KEY_LSB +: `SECV_TLEN];
        base     = int'({a[7:3], 3'b000});
        if (n == 0) begin
            e.err = 1'b1;
        end else if ((a[`SECV_ADR_WIDTH-1:0] & `SECV_ADR_FAULT_MASK) != 0) begin
            e.err   = 1'b1;
            e.ecode = op_is_load(op) ? ECODE_LOAD_ACCESS_FAULT : ECODE_STORE_ACCESS_FAULT;
        end else if (key != t[a[`SECV_GRANULE_LSB +: TAW]]) begin
            e.lat   = 1;
            e.err   = 1'b1;
            e.ecode = ECODE_TAG_FAULT;
        end else begin
            e.lat = 2;
            if (op_is_load(op)) begin
                // Upper bytes copy the top loaded bit or stay zero
                for (int i = 0; i < 8; i++) begin
                    if (i < n) begin
                        e.res[i*8 +: 8] = m[base + i];
                    end else if (op_is_signed(op)) begin
                        e.res[i*8 +: 8] = {8{m[base + n - 1][7]}};
                    end
                end
                e.res_wb = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic apply_store(input mem_op_t op, input xword_t a, input xword_t d);
        int base;
        base = int'({a[7:3], 3'b000});
        for (int i = 0; i < op_bytes(op); i++) begin
            mem_model[base + i] = d[i*8 +: 8];
        end
    endtask

    task automatic check_word(input string name, input xword_t got, input xword_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ecode(input string name, input ecode_t got, input ecode_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        chk_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("ERROR %0t rdy latency got %0d expected %0d", $time, got, exp);
        end
    endtask

    // Programming write, then one idle cycle for its ack
    task automatic program_tag(input logic [TAW-1:0] idx, input mtag_t val);
        @(posedge clk);
        #DRV_DLY;
        tag_wr     = 1'b1;
        tag_wr_adr = idx;
        tag_wr_dat = val;
        @(posedge clk);
        #DRV_DLY;
        tag_wr = 1'b0;
        tag_model[idx] = val;
    endtask

    task automatic do_req(input mem_op_t op, input xword_t a, input xword_t d);
        expect_t e;
        e = ref_result(op, a, d, mem_model, tag_model);
        @(posedge clk);
        #DRV_DLY;
        exp_q      = e;
        fu_in.ena  = 1'b1;
        fu_in.op   = op;
        fu_in.src1 = a;
        fu_in.src2 = d;
        do begin
            @(posedge clk);
        end while (!fu_out.rdy);
        #DRV_DLY;
        fu_in.ena = 1'b0;
        if (!e.err && !op_is_load(op)) begin
            apply_store(op, a, d);
        end
    endtask

    // Compare at the rdy edge
    always @(posedge clk) begin
        if (rst_n && fu_in.ena) begin
            if (fu_out.rdy) begin
                check_latency(ena_cycles, exp_q.lat);
                check_bit("fu_o.err", fu_out.err, exp_q.err);
                if (exp_q.err) begin
                    check_ecode("fu_o.ecode", fu_out.ecode, exp_q.ecode);
                end
                check_bit("fu_o.res_wb", fu_out.res_wb, exp_q.res_wb);
                if (exp_q.res_wb) begin
                    check_word("fu_o.res", fu_out.res, exp_q.res);
                end
                check_bit("tag_err_o", tag_err, exp_q.err && exp_q.ecode == ECODE_TAG_FAULT);
                ena_cycles = 0;
            end else begin
                ena_cycles++;
            end
        end else begin
            ena_cycles = 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a request never saw rdy", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        xword_t       w;
        xword_t       p;
        xword_t       mid;
        xword_t       d;
        mtag_t        key;
        mtag_t        old_tag;
        logic [8:0]   adr;
        logic [31:0]  rnd;
        logic [31:0]  rnd2;
        clk        = 1'b0;
        rst_n      = 1'b0;
        fu_in      = '0;
        tag_wr     = 1'b0;
        tag_wr_adr = '0;
        tag_wr_dat = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        // Known tags, then every data word
        for (int g = 0; g < `SECV_TAG_DEPTH; g++) begin
            program_tag(g[TAW-1:0], fill_tag(g));
        end
        for (int wi = 0; wi < MEM_BYTES / 8; wi++) begin
            for (int b = 0; b < 8; b++) begin
                w[b*8 +: 8] = fill_byte(wi * 8 + b);
            end
            do_req(MEM_OP_SD, make_ptr(tag_model[wi / 2], 9'(wi * 8)), w);
        end

        // Each store width, then loads of every width
        p = make_ptr(tag_model[4], 9'h48);
        for (int s = 7; s <= 10; s++) begin
            do_req(mem_op_t'(s), p, 64'hf1e2_d3c4_b5a6_9788 ^ {8{8'(s)}});
            for (int l = 0; l < 7; l++) begin
                do_req(mem_op_t'(l), p, '0);
            end
        end

        // One word in each bank
        for (int b = 0; b < `SECV_DMEM_BANKS; b++) begin
            do_req(MEM_OP_SD, make_ptr(tag_model[8 + b / 2], 9'(9'h80 + b * 8)),
                   64'hb0b0_0000_0000_0000 | 64'(b * 64'h1_0001));
        end
        for (int b = 0; b < `SECV_DMEM_BANKS; b++) begin
            do_req(MEM_OP_LD, make_ptr(tag_model[8 + b / 2], 9'(9'h80 + b * 8)), '0);
        end

        // Tag fault blocks the store
        old_tag = tag_model[5];
        program_tag(4'd5, old_tag ^ 16'hbeef);
        do_req(MEM_OP_SD, make_ptr(old_tag, 9'h50), 64'hdead_beef_dead_beef);
        do_req(MEM_OP_LD, make_ptr(old_tag, 9'h50), '0);
        do_req(MEM_OP_LD, make_ptr(tag_model[5], 9'h50), '0);

        // Outside the usable bytes
        do_req(MEM_OP_LW, make_ptr(tag_model[3], 9'h130), '0);
        do_req(MEM_OP_SH, make_ptr(tag_model[3], 9'h130), 64'h1234);

        for (int c = 11; c < 16; c++) begin
            do_req(mem_op_t'(c), make_ptr(tag_model[1], 9'h10), '1);
        end

        // Random mix with mostly matching keys
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            if (rnd[4:0] == 5'd0) begin
                rnd2 = $random(seed);
                program_tag(rnd2[3:0], rnd2[31:16]);
            end
            rnd  = $random(seed);
            rnd2 = $random(seed);
            adr  = {rnd[15:13] == 3'd0, rnd[12:5]};
            if (rnd2[2:0] == 3'd0) begin
                key = rnd2[31:16];
            end else begin
                key = tag_model[adr[7:4]];
            end
            mid = {$random(seed), $random(seed)};
            d   = {$random(seed), $random(seed)};
            do_req(mem_op_t'(rnd[3:0]), {key, mid[38:0], adr}, d);
        end

        @(posedge clk);
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, u_dut.u_props.fail_cnt);
        if (err_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsys.f
+incdir+rtl
rtl/secv_pkg.sv
rtl/wb_ram.sv
rtl/dmem_bank_dec.sv
rtl/dmem_resp_mux.sv
rtl/mtag_chk.sv
rtl/mem.sv
rtl/mem_subsys.sv
bench/mem_subsys_props.sv
bench/mem_subsys_tb.sv
